//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_backend
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/backend_checker.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module backend_checker (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic [4:0]       wb_rd_s,
    input logic [`XLEN-1:0] wb_rd_v,
    input logic             wb_regf_we,
    input logic [`XLEN-1:0] dbg_rs_v
);

    localparam int wb_timeout = 20;

    logic [4:0]       exp_rd [$];
    logic [`XLEN-1:0] exp_val [$];
    logic             exp_load [$];
    int               head_age = 0;
    int               stall_run = 0;
    int               low_run = 0;      // Low-stall cycles since the last stall cycle
    int               windows = 0;
    int               stall_errors = 0;
    int               checks = 0;
    int               errors = 0;
    int               test_errors = 0;
    int               tests = 0;

    function automatic void record_error();
        errors++;
        test_errors++;
    endfunction

    function automatic void drop_head();
        exp_rd.delete(0);
        exp_val.delete(0);
        exp_load.delete(0);
        head_age = 0;
    endfunction

    task automatic push_expected(input logic [4:0] rd, input logic [`XLEN-1:0] val,
                                 input logic we, input logic is_load);
        if (we) begin
            if (exp_rd.size() == 0) begin
                head_age = 0;
            end
            exp_rd.push_back(rd);
            exp_val.push_back(val);
            exp_load.push_back(is_load);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_regf_we) begin
                checks++;
                if (exp_rd.size() == 0) begin
                    $display("[ERROR] %0t: writeback to x%0d with nothing expected",
                             $time, wb_rd_s);
                    record_error();
                end else begin
                    if (wb_rd_s !== exp_rd[0] || wb_rd_v !== exp_val[0]) begin
                        $display("[ERROR] %0t: writeback x%0d = %h, expected x%0d = %h",
                                 $time, wb_rd_s, wb_rd_v, exp_rd[0], exp_val[0]);
                        record_error();
                    end
                    if (exp_load[0] && low_run != 1) begin
                        $display("[ERROR] %0t: load writeback %0d cycles after stall fell",
                                 $time, low_run);
                        record_error();
                    end
                    drop_head();
                end
            end else if (exp_rd.size() != 0) begin
                head_age++;
                if (head_age > wb_timeout) begin
                    $display("Timed out waiting for the writeback to x%0d", exp_rd[0]);
                    record_error();
                    drop_head();
                end
            end
            if (stall) begin
                stall_run++;
                low_run = 0;
            end else begin
                if (stall_run != 0) begin
                    windows++;
                    if (stall_run != `DMEM_LATENCY) begin
                        $display("[ERROR] %0t: stall high for %0d cycles, expected %0d",
                                 $time, stall_run, `DMEM_LATENCY);
                        record_error();
                        stall_errors++;
                    end
                end
                stall_run = 0;
                low_run++;
            end
        end
    end

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_rd.size() != 0 && cycles < 4 * wb_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_rd.size() != 0) begin
            $display("Writebacks still outstanding after %0d cycles", cycles);
            record_error();
        end
    endtask

    task automatic check_reg(input logic [4:0] idx, input logic [`XLEN-1:0] expected);
        checks++;
        if (dbg_rs_v !== expected) begin
            $display("[ERROR] %0t: x%0d reads %h, expected %h", $time, idx, dbg_rs_v, expected);
            record_error();
        end
    endtask

    task automatic check_idle();
        checks++;
        if (stall !== 1'b0 || wb_regf_we !== 1'b0) begin
            $display("[ERROR] %0t: stall = %b, wb_regf_we = %b after reset, expected 0 and 0",
                     $time, stall, wb_regf_we);
            record_error();
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic stall_report(input int mem_ops);
        tests++;
        checks++;
        if (windows != mem_ops) begin
            $display("[ERROR] %0t: %0d stall windows for %0d memory instructions",
                     $time, windows, mem_ops);
            record_error();
            stall_errors++;
        end
        $display("memory_stall: %0d windows, %0d errors", windows, stall_errors);
    endtask

    task automatic report_counts();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    endtask

endmodule

//--- dv/tb_backend.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module tb_backend
import rv32i_types_pkg::*;
();

    localparam int tbl_rows = 128;
    localparam int lcg_seed = 64831;
    localparam int accept_limit = 50;
    localparam logic [31:0] mem_base = 32'h100;
    localparam wb_sel_t load_sels [5] = '{lw_wb, lb_wb, lbu_wb, lh_wb, lhu_wb};
    localparam wb_sel_t alu_sels [4] = '{alu_out_wb, br_en_wb, u_imm_wb, pc_plus4_wb};

    logic             clk;
    logic             rst;
    logic             ex_valid;
    mem_op_t          ex_op;
    wb_sel_t          ex_wb_sel;
    logic             ex_regf_we;
    logic [4:0]       ex_rd_s;
    logic [`XLEN-1:0] ex_pc;
    logic [`XLEN-1:0] ex_alu_out;
    logic [`XLEN-1:0] ex_br_en;
    logic [`XLEN-1:0] ex_u_imm;
    logic [`XLEN-1:0] ex_mem_addr;
    logic [`XLEN-1:0] ex_store_data;
    logic [4:0]       dbg_rs_s;
    logic             stall;
    logic [4:0]       wb_rd_s;
    logic [`XLEN-1:0] wb_rd_v;
    logic             wb_regf_we;
    logic [`XLEN-1:0] dbg_rs_v;

    // Stimulus table with one instruction per row
    mem_op_t          t_op [tbl_rows];
    wb_sel_t          t_sel [tbl_rows];
    logic [4:0]       t_rd [tbl_rows];
    logic             t_we [tbl_rows];
    logic [`XLEN-1:0] t_pc [tbl_rows];
    logic [`XLEN-1:0] t_alu [tbl_rows];
    logic [`XLEN-1:0] t_br [tbl_rows];
    logic [`XLEN-1:0] t_uimm [tbl_rows];
    logic [`XLEN-1:0] t_addr [tbl_rows];
    logic [`XLEN-1:0] t_sdata [tbl_rows];
    logic [`XLEN-1:0] t_exp [tbl_rows];

    logic [`XLEN-1:0] shadow [`DMEM_WORDS];     // Expected data memory contents
    logic [`XLEN-1:0] sregs [`NUM_REGS];        // Expected register file contents
    logic [31:0]      lcg_state;
    logic [31:0]      r;
    int               n_rows;
    int               n_mem;
    int               sec_end [4];

    backend_top backend_top_i (.*);
    backend_checker checker_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] mem_addr(input logic [1:0] word, input logic [1:0] off);
        return mem_base | {28'b0, word, off};
    endfunction

    task automatic add_row(input mem_op_t op, input wb_sel_t sel, input logic [4:0] rd,
                           input logic we, input logic [31:0] addr, input logic [31:0] sdata);
        logic [31:0] word;
        logic [31:0] lane;
        logic [31:0] rv;
        int          off;
        int          nbytes;
        off = int'(addr[1:0]);
        word = shadow[addr[9:2]];
        lane = word >> (8 * off);       // Addressed byte now sits at bit 0
        rv = lcg_next();
        t_op[n_rows] = op;
        t_sel[n_rows] = sel;
        t_rd[n_rows] = rd;
        t_we[n_rows] = we;
        t_pc[n_rows] = {rv[31:2], 2'b00};
        t_alu[n_rows] = lcg_next();
        t_br[n_rows] = {31'b0, rv[7]};
        t_uimm[n_rows] = {rv[23:4], 12'h000};
        t_addr[n_rows] = addr;
        t_sdata[n_rows] = sdata;
        case (sel)
            alu_out_wb:  t_exp[n_rows] = t_alu[n_rows];
            br_en_wb:    t_exp[n_rows] = t_br[n_rows];
            u_imm_wb:    t_exp[n_rows] = t_uimm[n_rows];
            pc_plus4_wb: t_exp[n_rows] = t_pc[n_rows] + 32'd4;
            lw_wb:       t_exp[n_rows] = word;
            lb_wb:       t_exp[n_rows] = {{24{lane[7]}}, lane[7:0]};
            lbu_wb:      t_exp[n_rows] = {24'b0, lane[7:0]};
            lh_wb:       t_exp[n_rows] = {{16{lane[15]}}, lane[15:0]};
            default:     t_exp[n_rows] = {16'b0, lane[15:0]};
        endcase
        nbytes = (op == op_sb) ? 1 : (op == op_sh) ? 2 : (op == op_sw) ? 4 : 0;
        for (int b = 0; b < nbytes; b++) begin
            if (off + b < 4) begin      // Lanes past the word end are dropped
                shadow[addr[9:2]][8*(off+b) +: 8] = sdata[8*b +: 8];
            end
        end
        if (op != op_none) begin
            n_mem++;
        end
        n_rows++;
    endtask

    task automatic idle_inputs();
        ex_valid = 1'b0;
        ex_op = op_none;
        ex_wb_sel = alu_out_wb;
        ex_regf_we = 1'b0;
        ex_rd_s = 5'd0;
        ex_pc = '0;
        ex_alu_out = '0;
        ex_br_en = '0;
        ex_u_imm = '0;
        ex_mem_addr = '0;
        ex_store_data = '0;
    endtask

    task automatic wait_accept(input int row);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < accept_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            $display("Row %0d was never accepted, stall stayed high", row);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic run_rows(input int first, input int last);
        for (int i = first; i < last; i++) begin
            @(posedge clk);
            #1;
            ex_valid = 1'b1;
            ex_op = t_op[i];
            ex_wb_sel = t_sel[i];
            ex_regf_we = t_we[i];
            ex_rd_s = t_rd[i];
            ex_pc = t_pc[i];
            ex_alu_out = t_alu[i];
            ex_br_en = t_br[i];
            ex_u_imm = t_uimm[i];
            ex_mem_addr = t_addr[i];
            ex_store_data = t_sdata[i];
            checker_i.push_expected(t_rd[i], t_exp[i], t_we[i], t_op[i] == op_load);
            wait_accept(i);
            if (t_we[i] && t_rd[i] != 5'd0) begin
                sregs[t_rd[i]] = t_exp[i];
            end
        end
        @(posedge clk);
        #1;
        idle_inputs();
        checker_i.wait_drained();
    endtask

    task automatic read_regs();
        for (int i = 0; i < `NUM_REGS; i++) begin
            @(posedge clk);
            #1;
            dbg_rs_s = 5'(i);
            @(negedge clk);
            checker_i.check_reg(5'(i), sregs[i]);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dbg_rs_s = 5'd0;
        idle_inputs();
        lcg_state = lcg_seed;
        n_rows = 0;
        n_mem = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            sregs[i] = '0;
        end
        add_row(op_none, alu_out_wb, 5'd1, 1'b1, 32'd0, 32'd0);
        add_row(op_none, br_en_wb, 5'd2, 1'b1, 32'd0, 32'd0);
        add_row(op_none, u_imm_wb, 5'd3, 1'b1, 32'd0, 32'd0);
        add_row(op_none, pc_plus4_wb, 5'd4, 1'b1, 32'd0, 32'd0);
        add_row(op_none, alu_out_wb, 5'd31, 1'b1, 32'd0, 32'd0);
        add_row(op_none, pc_plus4_wb, 5'd5, 1'b1, 32'd0, 32'd0);
        sec_end[0] = n_rows;
        add_row(op_none, alu_out_wb, 5'd0, 1'b1, 32'd0, 32'd0);     // x0 must stay zero
        add_row(op_none, alu_out_wb, 5'd6, 1'b0, 32'd0, 32'd0);
        add_row(op_none, u_imm_wb, 5'd1, 1'b0, 32'd0, 32'd0);
        sec_end[1] = n_rows;
        for (int w = 0; w < 4; w++) begin
            add_row(op_sw, alu_out_wb, 5'd0, 1'b0, mem_addr(2'(w), 2'd0), lcg_next());
        end
        for (int off = 0; off < 4; off++) begin
            add_row(op_sh, alu_out_wb, 5'd0, 1'b0, mem_addr(2'd1, 2'(off)), lcg_next());
            add_row(op_sb, alu_out_wb, 5'd0, 1'b0, mem_addr(2'd2, 2'(off)), lcg_next());
        end
        for (int w = 1; w < 3; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 5; k++) begin
                    add_row(op_load, load_sels[k], 5'(8 + off * 5 + k), 1'b1,
                            mem_addr(2'(w), 2'(off)), 32'd0);
                end
            end
        end
        sec_end[2] = n_rows;
        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            if (r[1:0] == 2'd0) begin
                add_row(op_none, alu_sels[r[3:2]], r[8:4], r[11:9] != 3'd0, 32'd0, 32'd0);
            end else if (r[1:0] == 2'd1) begin
                if (r[3:2] == 2'd0) begin
                    add_row(op_sb, alu_out_wb, 5'd0, 1'b0, mem_addr(r[6:5], r[8:7]), lcg_next());
                end else if (r[3:2] == 2'd1) begin
                    add_row(op_sh, alu_out_wb, 5'd0, 1'b0, mem_addr(r[6:5], r[8:7]), lcg_next());
                end else begin
                    add_row(op_sw, alu_out_wb, 5'd0, 1'b0, mem_addr(r[6:5], 2'd0), lcg_next());
                end
            end else begin
                add_row(op_load, load_sels[r[4:2] % 3'd5], r[9:5], 1'b1,
                        mem_addr(r[11:10], r[13:12]), 32'd0);
            end
        end
        sec_end[3] = n_rows;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checker_i.check_idle();
        read_regs();
        checker_i.end_test("reset_idle");
        run_rows(0, sec_end[0]);
        read_regs();
        checker_i.end_test("alu_sources");
        run_rows(sec_end[0], sec_end[1]);
        read_regs();
        checker_i.end_test("x0_and_disabled");
        run_rows(sec_end[1], sec_end[2]);
        read_regs();
        checker_i.end_test("stores_loads");
        run_rows(sec_end[2], sec_end[3]);
        read_regs();
        checker_i.end_test("random_stream");
        checker_i.stall_report(n_mem);
        checker_i.report_counts();
        if (checker_i.errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/backend_params.svh
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// Data path width
`define XLEN 32

// Architectural register count
`define NUM_REGS 32

// Data memory depth in words and wait cycles per access
`define DMEM_WORDS 256
`define DMEM_LATENCY 3

`endif

//--- src/backend_top.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module backend_top
import rv32i_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid,
    input  mem_op_t            ex_op,
    input  wb_sel_t            ex_wb_sel,
    input  logic               ex_regf_we,
    input  logic [4:0]         ex_rd_s,
    input  logic [`XLEN-1:0]   ex_pc,
    input  logic [`XLEN-1:0]   ex_alu_out,
    input  logic [`XLEN-1:0]   ex_br_en,
    input  logic [`XLEN-1:0]   ex_u_imm,
    input  logic [`XLEN-1:0]   ex_mem_addr,
    input  logic [`XLEN-1:0]   ex_store_data,
    input  logic [4:0]         dbg_rs_s,
    output logic               stall,
    output logic [4:0]         wb_rd_s,
    output logic [`XLEN-1:0]   wb_rd_v,
    output logic               wb_regf_we,
    output logic [`XLEN-1:0]   dbg_rs_v
);

    logic             timer_start;
    logic             timer_done;
    logic             mem_fire;
    logic             stage_load;
    logic [`XLEN-1:0] rdata;

    logic             wb_valid;
    wb_sel_t          wb_sel_q;
    logic             regf_we_q;
    logic [4:0]       rd_s_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] alu_out_q;
    logic [`XLEN-1:0] br_en_q;
    logic [`XLEN-1:0] u_imm_q;
    logic [`XLEN-1:0] lw_q;
    logic [`XLEN-1:0] lb_q;
    logic [`XLEN-1:0] lbu_q;
    logic [`XLEN-1:0] lh_q;
    logic [`XLEN-1:0] lhu_q;

    mem_access_fsm mem_access_fsm_i (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_op(ex_op),
        .timer_done(timer_done), .stall(stall), .timer_start(timer_start),
        .mem_fire(mem_fire), .stage_load(stage_load)
    );

    mem_wait_timer mem_wait_timer_i (
        .clk(clk), .rst(rst), .start(timer_start), .done(timer_done)
    );

    data_mem data_mem_i (
        .clk(clk), .mem_fire(mem_fire), .op(ex_op), .addr(ex_mem_addr),
        .store_data(ex_store_data), .rdata(rdata)
    );

    mem_wb_align mem_wb_align_i (
        .clk(clk), .rst(rst), .stage_load(stage_load), .ex_valid(ex_valid),
        .wb_sel(ex_wb_sel), .regf_we(ex_regf_we), .rd_s(ex_rd_s), .pc(ex_pc),
        .alu_out(ex_alu_out), .br_en(ex_br_en), .u_imm(ex_u_imm),
        .addr_lo(ex_mem_addr[1:0]), .rdata(rdata),
        .wb_valid(wb_valid), .wb_sel_q(wb_sel_q), .regf_we_q(regf_we_q),
        .rd_s_q(rd_s_q), .pc_q(pc_q), .alu_out_q(alu_out_q), .br_en_q(br_en_q),
        .u_imm_q(u_imm_q), .lw_q(lw_q), .lb_q(lb_q), .lbu_q(lbu_q),
        .lh_q(lh_q), .lhu_q(lhu_q)
    );

    wb_stage wb_stage_i (
        .wb_valid(wb_valid), .wb_sel(wb_sel_q), .regf_we(regf_we_q),
        .rd_s(rd_s_q), .pc(pc_q), .alu_out(alu_out_q), .br_en(br_en_q),
        .u_imm(u_imm_q), .lw(lw_q), .lb(lb_q), .lbu(lbu_q), .lh(lh_q),
        .lhu(lhu_q), .wb_rd_s(wb_rd_s), .wb_rd_v(wb_rd_v),
        .wb_regf_we(wb_regf_we)
    );

    regfile #(
        .AW(5)
    ) regfile_i (
        .clk(clk), .rst(rst), .we(wb_regf_we), .rd_s(wb_rd_s), .rd_v(wb_rd_v),
        .dbg_rs_s(dbg_rs_s), .dbg_rs_v(dbg_rs_v)
    );

endmodule

//--- src/data_mem.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module data_mem
import rv32i_types_pkg::*;
(
    input  logic               clk,
    input  logic               mem_fire,
    input  mem_op_t            op,
    input  logic [`XLEN-1:0]   addr,
    input  logic [`XLEN-1:0]   store_data,
    output logic [`XLEN-1:0]   rdata
);

    localparam int AW = $clog2(`DMEM_WORDS);
    localparam int NB = `XLEN / 8;

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    word_idx;
    logic [NB-1:0]    wmask;
    logic [`XLEN-1:0] wdata;

    assign word_idx = addr[AW+1:2];

    always_comb begin
        wmask = '0;
        wdata = store_data << (8 * addr[1:0]);     // Move narrow data up to its lane
        case (op)
            op_sb:   wmask = NB'(4'b0001) << addr[1:0];
            op_sh:   wmask = NB'(4'b0011) << addr[1:0];
            op_sw:   wmask = '1;
            default: wmask = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_fire) begin
            for (int b = 0; b < NB; b++) begin
                if (wmask[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read word feeds the lane logic in MEM/WB directly
    assign rdata = mem[word_idx];

endmodule

//--- src/mem_access_fsm.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module mem_access_fsm
import rv32i_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    ex_valid,
    input  mem_op_t ex_op,
    input  logic    timer_done,
    output logic    stall,
    output logic    timer_start,
    output logic    mem_fire,
    output logic    stage_load
);

    mem_state_t state;
    mem_state_t state_next;
    logic       is_mem_op;

    assign is_mem_op = (ex_op != op_none);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next  = state;
        stall       = 1'b0;
        timer_start = 1'b0;
        mem_fire    = 1'b0;
        stage_load  = 1'b0;
        case (state)
            st_idle: begin
                if (ex_valid && is_mem_op) begin
                    stall       = 1'b1;     // Hold upstream from the first cycle
                    timer_start = 1'b1;
                    state_next  = st_wait;
                end else if (ex_valid) begin
                    stage_load  = 1'b1;     // Non-memory ops pass straight to MEM/WB
                end
            end
            st_wait: begin
                if (timer_done) begin
                    mem_fire    = 1'b1;     // Instruction is taken in this cycle
                    stage_load  = 1'b1;
                    state_next  = st_idle;
                end else begin
                    stall       = 1'b1;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Memory fires exactly one latency after the access started
    fire_after_wait: assert property (@(posedge clk) disable iff (rst)
        mem_fire |-> $past(timer_start, `DMEM_LATENCY))
        else $error("mem_fire in state %s without a start %0d cycles earlier",
                    state.name(), `DMEM_LATENCY);

    // Back-pressure is bounded by the memory latency
    stall_bounded: assert property (@(posedge clk) disable iff (rst)
        stall [*`DMEM_LATENCY] |=> !stall)
        else $error("stall held longer than %0d cycles", `DMEM_LATENCY);

endmodule

//--- src/mem_wait_timer.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module mem_wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    localparam int CW = $clog2(`DMEM_LATENCY + 1);

    logic [CW-1:0] count;
    logic          running;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= CW'(`DMEM_LATENCY - 1);   // Last cycle is the one at zero
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign done = running && (count == '0);

    // Sequencer must wait for the previous access to finish
    no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !running)
        else $error("timer restarted while running");

endmodule

//--- src/mem_wb_align.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module mem_wb_align
import rv32i_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               stage_load,
    input  logic               ex_valid,
    input  wb_sel_t            wb_sel,
    input  logic               regf_we,
    input  logic [4:0]         rd_s,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   alu_out,
    input  logic [`XLEN-1:0]   br_en,
    input  logic [`XLEN-1:0]   u_imm,
    input  logic [1:0]         addr_lo,
    input  logic [`XLEN-1:0]   rdata,
    output logic               wb_valid,
    output wb_sel_t            wb_sel_q,
    output logic               regf_we_q,
    output logic [4:0]         rd_s_q,
    output logic [`XLEN-1:0]   pc_q,
    output logic [`XLEN-1:0]   alu_out_q,
    output logic [`XLEN-1:0]   br_en_q,
    output logic [`XLEN-1:0]   u_imm_q,
    output logic [`XLEN-1:0]   lw_q,
    output logic [`XLEN-1:0]   lb_q,
    output logic [`XLEN-1:0]   lbu_q,
    output logic [`XLEN-1:0]   lh_q,
    output logic [`XLEN-1:0]   lhu_q
);

    logic [`XLEN-1:0] shifted;

    assign shifted = rdata >> (8 * addr_lo);   // Addressed byte lands in bits 7:0

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= stage_load && ex_valid;     // Empty cycles leave a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load) begin
            wb_sel_q  <= wb_sel;
            regf_we_q <= regf_we;
            rd_s_q    <= rd_s;
            pc_q      <= pc;
            alu_out_q <= alu_out;
            br_en_q   <= br_en;
            u_imm_q   <= u_imm;
            lw_q      <= rdata;
            lb_q      <= {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            lbu_q     <= {{(`XLEN-8){1'b0}}, shifted[7:0]};
            lh_q      <= {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            lhu_q     <= {{(`XLEN-16){1'b0}}, shifted[15:0]};
        end
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module regfile #(
    parameter int AW = $clog2(`NUM_REGS)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  logic [AW-1:0]      rd_s,
    input  logic [`XLEN-1:0]   rd_v,
    input  logic [AW-1:0]      dbg_rs_s,
    output logic [`XLEN-1:0]   dbg_rs_v
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_s != '0)) begin
            regs[rd_s] <= rd_v;     // x0 is never written
        end
    end

    // No write bypass so a new value shows up the cycle after the write
    assign dbg_rs_v = regs[dbg_rs_s];

endmodule

//--- src/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // Writeback source select, order follows the decoder encoding
    typedef enum logic [3:0] {
        alu_out_wb  = 4'd0,
        br_en_wb    = 4'd1,
        u_imm_wb    = 4'd2,
        lw_wb       = 4'd3,
        pc_plus4_wb = 4'd4,
        lb_wb       = 4'd5,
        lbu_wb      = 4'd6,
        lh_wb       = 4'd7,
        lhu_wb      = 4'd8
    } wb_sel_t;

    // Memory operation carried by each instruction
    typedef enum logic [2:0] {
        op_none = 3'd0,         // No data memory access
        op_load = 3'd1,         // Load width comes from the writeback select
        op_sb   = 3'd2,
        op_sh   = 3'd3,
        op_sw   = 3'd4
    } mem_op_t;

    // Access sequencer states
    typedef enum logic {
        st_idle = 1'b0,
        st_wait = 1'b1
    } mem_state_t;

endpackage

//--- src/wb_stage.sv
`timescale 1ns/10ps
`include "backend_params.svh"

module wb_stage
import rv32i_types_pkg::*;
(
    input  logic               wb_valid,
    input  wb_sel_t            wb_sel,
    input  logic               regf_we,
    input  logic [4:0]         rd_s,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   alu_out,
    input  logic [`XLEN-1:0]   br_en,
    input  logic [`XLEN-1:0]   u_imm,
    input  logic [`XLEN-1:0]   lw,
    input  logic [`XLEN-1:0]   lb,
    input  logic [`XLEN-1:0]   lbu,
    input  logic [`XLEN-1:0]   lh,
    input  logic [`XLEN-1:0]   lhu,
    output logic [4:0]         wb_rd_s,
    output logic [`XLEN-1:0]   wb_rd_v,
    output logic               wb_regf_we
);

    always_comb begin
        case (wb_sel)
            alu_out_wb:  wb_rd_v = alu_out;
            br_en_wb:    wb_rd_v = br_en;
            u_imm_wb:    wb_rd_v = u_imm;
            lw_wb:       wb_rd_v = lw;
            pc_plus4_wb: wb_rd_v = pc + `XLEN'd4;    // Link value for jal and jalr
            lb_wb:       wb_rd_v = lb;
            lbu_wb:      wb_rd_v = lbu;
            lh_wb:       wb_rd_v = lh;
            lhu_wb:      wb_rd_v = lhu;
            default:     wb_rd_v = '0;
        endcase
    end

    assign wb_rd_s    = rd_s;
    assign wb_regf_we = regf_we && wb_valid;    // Bubbles never write

endmodule

//--- tb.f
+incdir+src
src/rv32i_types_pkg.sv
src/mem_access_fsm.sv
src/mem_wait_timer.sv
src/data_mem.sv
src/mem_wb_align.sv
src/wb_stage.sv
src/regfile.sv
src/backend_top.sv
dv/backend_checker.sv
dv/tb_backend.sv
